//--- Makefile
# Verilator build and run for the accelerator testbench
VERILATOR  ?= verilator
TOP        ?= accel_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
source/accel_pkg.sv
source/sync_fifo.sv
source/cmd_dispatch.sv
source/solution_checker.sv
source/modmul_unit.sv
source/resp_merge.sv
source/accel_top.sv
test/accel_asserts.sv
test/accel_tb.sv

//--- source/accel_pkg.sv
// Accelerator shared definitions
package accel_pkg;

  // Host command and response words share one layout
  typedef logic [63:0] cmd_t;  // Opcode | tag | payload
  typedef logic [63:0] resp_t; // Opcode | tag | result

  // Field positions
  localparam int OP_HI  = 63;
  localparam int OP_LO  = 60;
  localparam int TAG_HI = 59;
  localparam int TAG_LO = 56;
  localparam int PAY_W  = 56; // Payload and result width

  // Checker payload
  localparam int LAST_BIT = 55; // Last index of a solution
  localparam int IDX_W    = 32; // Index in bits 31..0

  // Multiplier payload, operand a above operand b
  localparam int OPA_LO = 24;
  localparam int OPB_LO = 0;

  // Opcodes, anything else is dropped by the dispatcher
  localparam logic [3:0] OP_USR_RST = 4'h1; // Clear both engines
  localparam logic [3:0] OP_CHK_IDX = 4'h2; // One solution index
  localparam logic [3:0] OP_MODMUL  = 4'h3; // a * b mod p

  // Checker error mask bits
  localparam int MASK_ORDER = 0; // Index not strictly ascending
  localparam int MASK_COUNT = 1; // Wrong number of indices
  localparam int MASK_XOR   = 2; // XOR of all indices not zero
  localparam int MASK_W     = 3;

  // Default parameter values, the top passes these down
  localparam int          SOL_LEN_DEF    = 8;
  localparam int          MUL_W_DEF      = 24;
  localparam int unsigned MUL_P_DEF      = 16777213; // Largest prime below 2^24
  localparam int          FIFO_DEPTH_DEF = 4;

endpackage

//--- source/accel_top.sv
// Verification accelerator top
module accel_top import accel_pkg::*; #(
  parameter int          SOL_LEN    = SOL_LEN_DEF,
  parameter int          MUL_W      = MUL_W_DEF,
  parameter int unsigned MUL_P      = MUL_P_DEF,
  parameter int          FIFO_DEPTH = FIFO_DEPTH_DEF
)(
  input  logic  i_clk_100,
  input  logic  i_rst_n,
  input  logic  i_rx_val,  // Host command strobe
  input  cmd_t  i_rx_dat,
  output logic  o_tx_val,  // Response strobe
  output resp_t o_tx_dat
);

  logic  chk_val;
  cmd_t  chk_cmd;
  logic  mul_val;
  cmd_t  mul_cmd;
  logic  usr_rst;     // Clears engines and merger, not the port reset
  logic  chk_res_val;
  resp_t chk_res_dat;
  logic  mul_res_val;
  resp_t mul_res_dat;

  cmd_dispatch dispatch_inst (
    .i_clk_100 ( i_clk_100 ),
    .i_rst_n   ( i_rst_n   ),
    .i_rx_val  ( i_rx_val  ),
    .i_rx_dat  ( i_rx_dat  ),
    .o_chk_val ( chk_val   ),
    .o_chk_dat ( chk_cmd   ),
    .o_mul_val ( mul_val   ),
    .o_mul_dat ( mul_cmd   ),
    .o_usr_rst ( usr_rst   )
  );

  solution_checker #(.SOL_LEN(SOL_LEN)) checker_inst (
    .i_clk_100 ( i_clk_100   ),
    .i_rst_n   ( i_rst_n     ),
    .i_clr     ( usr_rst     ),
    .i_val     ( chk_val     ),
    .i_dat     ( chk_cmd     ),
    .o_res_val ( chk_res_val ),
    .o_res_dat ( chk_res_dat )
  );

  modmul_unit #(
    .MUL_W      ( MUL_W      ),
    .MUL_P      ( MUL_P      ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) modmul_inst (
    .i_clk_100 ( i_clk_100   ),
    .i_rst_n   ( i_rst_n     ),
    .i_clr     ( usr_rst     ),
    .i_val     ( mul_val     ),
    .i_dat     ( mul_cmd     ),
    .o_res_val ( mul_res_val ),
    .o_res_dat ( mul_res_dat )
  );

  resp_merge #(.FIFO_DEPTH(FIFO_DEPTH)) merge_inst (
    .i_clk_100 ( i_clk_100   ),
    .i_rst_n   ( i_rst_n     ),
    .i_clr     ( usr_rst     ),
    .i_chk_val ( chk_res_val ),
    .i_chk_dat ( chk_res_dat ),
    .i_mul_val ( mul_res_val ),
    .i_mul_dat ( mul_res_dat ),
    .o_tx_val  ( o_tx_val    ),
    .o_tx_dat  ( o_tx_dat    )
  );

endmodule

//--- source/cmd_dispatch.sv
// Host command dispatcher
module cmd_dispatch import accel_pkg::*; (
  input  logic i_clk_100,
  input  logic i_rst_n,
  input  logic i_rx_val,  // Host word strobe
  input  cmd_t i_rx_dat,
  output logic o_chk_val, // Index word for the checker
  output cmd_t o_chk_dat,
  output logic o_mul_val, // Operation for the multiplier
  output cmd_t o_mul_dat,
  output logic o_usr_rst  // One-cycle engine clear
);

  cmd_t       cmd_q; // Registered host word
  logic [3:0] op;
  logic       is_chk;
  logic       is_mul;
  logic       is_rst;

  // Decode once here, engines trust their strobe
  assign op     = i_rx_dat[OP_HI:OP_LO];
  assign is_chk = i_rx_val && (op == OP_CHK_IDX);
  assign is_mul = i_rx_val && (op == OP_MODMUL);
  assign is_rst = i_rx_val && (op == OP_USR_RST);

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_chk_val <= 1'b0;
      o_mul_val <= 1'b0;
      o_usr_rst <= 1'b0;
    end else begin
      o_chk_val <= is_chk; // Unknown opcodes raise nothing
      o_mul_val <= is_mul;
      o_usr_rst <= is_rst;
    end
  end

  // Word only loaded when it goes to an engine
  always_ff @(posedge i_clk_100) begin
    if (is_chk || is_mul) cmd_q <= i_rx_dat;
  end

  // Both engines see the same register, only the strobes differ
  assign o_chk_dat = cmd_q;
  assign o_mul_dat = cmd_q;

endmodule

//--- source/modmul_unit.sv
// Queued modular multiplier
module modmul_unit import accel_pkg::*; #(
  parameter int          MUL_W      = MUL_W_DEF,     // Operand width
  parameter int unsigned MUL_P      = MUL_P_DEF,     // Modulus
  parameter int          FIFO_DEPTH = FIFO_DEPTH_DEF // Queued operations
)(
  input  logic  i_clk_100,
  input  logic  i_rst_n,
  input  logic  i_clr,     // User reset
  input  logic  i_val,
  input  cmd_t  i_dat,
  output logic  o_res_val, // One per operation, in command order
  output resp_t o_res_dat
);

  localparam int             CNT_W = $clog2(MUL_W + 1);
  localparam logic [MUL_W:0] P_EXT = (MUL_W + 1)'(MUL_P); // One spare bit for compares

  cmd_t             fifo_dat;
  logic             fifo_empty;
  logic             pop;
  logic             busy;
  logic [CNT_W-1:0] step_cnt; // Steps left minus one
  logic             step_last;

  // Operation in progress
  logic [MUL_W-1:0] a_q;
  logic [MUL_W-1:0] b_q; // Shifted left, MSB is the current bit
  logic [MUL_W-1:0] acc_q;
  logic [3:0]       op_q;
  logic [3:0]       tag_q;

  logic [MUL_W:0]   a_ext;
  logic [MUL_W-1:0] a_red;
  logic [MUL_W:0]   dbl;
  logic [MUL_W-1:0] dbl_r;
  logic [MUL_W:0]   sum;
  logic [MUL_W-1:0] sum_r;
  logic [MUL_W-1:0] acc_nxt;

  assign pop       = !busy && !fifo_empty && !i_clr; // Next op only when idle
  assign step_last = busy && (step_cnt == '0);

  sync_fifo #(
    .DEPTH ( FIFO_DEPTH ),
    .T     ( cmd_t      )
  ) cmd_fifo_inst (
    .i_clk_100 ( i_clk_100  ),
    .i_rst_n   ( i_rst_n    ),
    .i_clr     ( i_clr      ),
    .i_wr      ( i_val      ),
    .i_wr_dat  ( i_dat      ),
    .i_rd      ( pop        ),
    .o_rd_dat  ( fifo_dat   ),
    .o_empty   ( fifo_empty ),
    .o_full    (            )
  );

  always_comb begin
    // a can reach 2^MUL_W-1, so bring it below p once on load
    a_ext   = {1'b0, fifo_dat[OPA_LO +: MUL_W]};
    a_red   = (a_ext >= P_EXT) ? MUL_W'(a_ext - P_EXT) : a_ext[MUL_W-1:0];
    dbl     = {acc_q, 1'b0};                                          // 2*acc < 2p
    dbl_r   = (dbl >= P_EXT) ? MUL_W'(dbl - P_EXT) : dbl[MUL_W-1:0];
    sum     = {1'b0, dbl_r} + {1'b0, a_q};                            // Also < 2p
    sum_r   = (sum >= P_EXT) ? MUL_W'(sum - P_EXT) : sum[MUL_W-1:0];
    acc_nxt = b_q[MUL_W-1] ? sum_r : dbl_r;
  end

  // Control: one load cycle then MUL_W steps
  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy      <= 1'b0;
      step_cnt  <= '0;
      o_res_val <= 1'b0;
    end else if (i_clr) begin
      busy      <= 1'b0; // Abandon any running product
      step_cnt  <= '0;
      o_res_val <= 1'b0;
    end else begin
      o_res_val <= step_last;
      if (pop) begin
        busy     <= 1'b1;
        step_cnt <= CNT_W'(MUL_W - 1);
      end else if (busy) begin
        step_cnt <= step_cnt - 1'b1;
        if (step_last) busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (pop) begin
      a_q   <= a_red;
      b_q   <= fifo_dat[OPB_LO +: MUL_W];
      acc_q <= '0;
      op_q  <= fifo_dat[OP_HI:OP_LO];
      tag_q <= fifo_dat[TAG_HI:TAG_LO];
    end else if (busy) begin
      acc_q <= acc_nxt;
      b_q   <= b_q << 1; // MSB first
    end
    if (step_last) o_res_dat <= {op_q, tag_q, {(PAY_W - MUL_W){1'b0}}, acc_nxt};
  end

endmodule

//--- source/resp_merge.sv
// Round-robin response merger
module resp_merge import accel_pkg::*; #(
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF // Per-engine result queue
)(
  input  logic  i_clk_100,
  input  logic  i_rst_n,
  input  logic  i_clr,     // User reset flushes both queues
  input  logic  i_chk_val,
  input  resp_t i_chk_dat,
  input  logic  i_mul_val,
  input  resp_t i_mul_dat,
  output logic  o_tx_val,  // One-cycle strobe, no back-pressure
  output resp_t o_tx_dat
);

  resp_t chk_dat;
  resp_t mul_dat;
  logic  chk_empty;
  logic  mul_empty;
  logic  rr_q;     // Set gives the multiplier queue first pick
  logic  pick_mul;
  logic  rd_chk;
  logic  rd_mul;

  // Only one queue drains per cycle, the other waits its turn
  assign pick_mul = !mul_empty && (chk_empty || rr_q);
  assign rd_mul   = pick_mul && !i_clr;
  assign rd_chk   = !chk_empty && !pick_mul && !i_clr;

  sync_fifo #(
    .DEPTH ( FIFO_DEPTH ),
    .T     ( resp_t     )
  ) chk_fifo_inst (
    .i_clk_100 ( i_clk_100 ),
    .i_rst_n   ( i_rst_n   ),
    .i_clr     ( i_clr     ),
    .i_wr      ( i_chk_val ),
    .i_wr_dat  ( i_chk_dat ),
    .i_rd      ( rd_chk    ),
    .o_rd_dat  ( chk_dat   ),
    .o_empty   ( chk_empty ),
    .o_full    (           )
  );

  sync_fifo #(
    .DEPTH ( FIFO_DEPTH ),
    .T     ( resp_t     )
  ) mul_fifo_inst (
    .i_clk_100 ( i_clk_100 ),
    .i_rst_n   ( i_rst_n   ),
    .i_clr     ( i_clr     ),
    .i_wr      ( i_mul_val ),
    .i_wr_dat  ( i_mul_dat ),
    .i_rd      ( rd_mul    ),
    .o_rd_dat  ( mul_dat   ),
    .o_empty   ( mul_empty ),
    .o_full    (           )
  );

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tx_val <= 1'b0;
      rr_q     <= 1'b0;
    end else if (i_clr) begin
      o_tx_val <= 1'b0;
      rr_q     <= 1'b0;
    end else begin
      o_tx_val <= rd_chk || rd_mul;
      if (rd_chk)      rr_q <= 1'b1; // Hand priority to the other side
      else if (rd_mul) rr_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (rd_chk || rd_mul) o_tx_dat <= pick_mul ? mul_dat : chk_dat;
  end

endmodule

//--- source/solution_checker.sv
// Streamed solution checker
module solution_checker import accel_pkg::*; #(
  parameter int SOL_LEN = SOL_LEN_DEF // Indices in a valid solution
)(
  input  logic  i_clk_100,
  input  logic  i_rst_n,
  input  logic  i_clr,     // User reset
  input  logic  i_val,
  input  cmd_t  i_dat,
  output logic  o_res_val, // One per completed solution
  output resp_t o_res_dat
);

  localparam int               CNT_W   = $clog2(SOL_LEN + 2);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(SOL_LEN + 1); // Enough to flag too many

  // Running state of the current solution
  logic [IDX_W-1:0]  prev_idx;
  logic [IDX_W-1:0]  xor_acc;
  logic [CNT_W-1:0]  cnt;
  logic              order_err; // Sticky

  logic [IDX_W-1:0]  idx;
  logic              last;
  logic              ord_now;
  logic [IDX_W-1:0]  xor_nxt;
  logic [CNT_W-1:0]  cnt_nxt;
  logic [MASK_W-1:0] mask;

  always_comb begin
    idx     = i_dat[IDX_W-1:0];
    last    = i_dat[LAST_BIT];
    ord_now = (cnt != '0) && (idx <= prev_idx); // First index has nothing before it
    xor_nxt = xor_acc ^ idx;
    cnt_nxt = (cnt == CNT_MAX) ? cnt : cnt + 1'b1; // Saturate
    // Mask as it stands with this word included
    mask             = '0;
    mask[MASK_ORDER] = order_err || ord_now;
    mask[MASK_COUNT] = (cnt_nxt != CNT_W'(SOL_LEN));
    mask[MASK_XOR]   = (xor_nxt != '0);
  end

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cnt       <= '0;
      xor_acc   <= '0;
      order_err <= 1'b0;
      o_res_val <= 1'b0;
    end else if (i_clr) begin
      cnt       <= '0; // Partial solution discarded
      xor_acc   <= '0;
      order_err <= 1'b0;
      o_res_val <= 1'b0;
    end else begin
      o_res_val <= i_val && last;
      if (i_val && last) begin
        cnt       <= '0; // Ready for the next solution
        xor_acc   <= '0;
        order_err <= 1'b0;
      end else if (i_val) begin
        cnt       <= cnt_nxt;
        xor_acc   <= xor_nxt;
        order_err <= order_err || ord_now;
      end
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (i_val) prev_idx <= idx; // Ignored while cnt is zero
    if (i_val && last) begin
      // Echo opcode and tag of the last word
      o_res_dat <= {i_dat[OP_HI:OP_LO], i_dat[TAG_HI:TAG_LO],
                    {(PAY_W - MASK_W){1'b0}}, mask};
    end
  end

endmodule

//--- source/sync_fifo.sv
// Single-clock FIFO
module sync_fifo #(
  parameter int  DEPTH = 4,            // Entries
  parameter type T     = logic [63:0]  // Payload type
)(
  input  logic i_clk_100,
  input  logic i_rst_n,
  input  logic i_clr,     // Synchronous flush
  input  logic i_wr,
  input  T     i_wr_dat,
  input  logic i_rd,
  output T     o_rd_dat,  // Head word, valid while not empty
  output logic o_empty,
  output logic o_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign o_empty  = (count == '0);
  assign o_full   = (count == CNT_W'(DEPTH));
  assign wr_en    = i_wr && !o_full;  // Write to a full queue is lost
  assign rd_en    = i_rd && !o_empty;
  assign o_rd_dat = mem[rd_ptr];      // First word fall-through

  always_ff @(posedge i_clk_100 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (i_clr) begin
      wr_ptr <= '0; // Flush drops everything held
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= ptr_inc(wr_ptr);
      if (rd_en) rd_ptr <= ptr_inc(rd_ptr);
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (wr_en) mem[wr_ptr] <= i_wr_dat;
  end

endmodule

//--- test/accel_asserts.sv
// Accelerator bound checks
module accel_asserts (
  input logic i_clk_100,
  input logic i_rst_n,
  input logic i_tx_val,    // Response strobe
  input logic i_chk_val,   // Dispatcher strobes
  input logic i_mul_val,
  input logic i_usr_rst,
  input logic i_cmd_wr,    // Multiplier command queue
  input logic i_cmd_full,
  input logic i_rchk_wr,   // Merger checker queue
  input logic i_rchk_full,
  input logic i_rmul_wr,   // Merger product queue
  input logic i_rmul_full
);

  tx_val_known: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    !$isunknown(i_tx_val))
    else $error("o_tx_val is unknown out of reset");

  // Host keeps outstanding products within the queue depth
  cmd_no_overflow: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    !(i_cmd_wr && i_cmd_full))
    else $error("write to a full multiplier command queue");

  rchk_no_overflow: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    !(i_rchk_wr && i_rchk_full))
    else $error("write to a full checker result queue");

  rmul_no_overflow: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    !(i_rmul_wr && i_rmul_full))
    else $error("write to a full product result queue");

  one_strobe: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    $onehot0({i_chk_val, i_mul_val, i_usr_rst}))
    else $error("dispatcher raised more than one strobe in a cycle");

endmodule

bind accel_top accel_asserts accel_asserts_inst (
  .i_clk_100   ( i_clk_100                        ),
  .i_rst_n     ( i_rst_n                          ),
  .i_tx_val    ( o_tx_val                         ),
  .i_chk_val   ( chk_val                          ),
  .i_mul_val   ( mul_val                          ),
  .i_usr_rst   ( usr_rst                          ),
  .i_cmd_wr    ( modmul_inst.cmd_fifo_inst.i_wr   ),
  .i_cmd_full  ( modmul_inst.cmd_fifo_inst.o_full ),
  .i_rchk_wr   ( merge_inst.chk_fifo_inst.i_wr    ),
  .i_rchk_full ( merge_inst.chk_fifo_inst.o_full  ),
  .i_rmul_wr   ( merge_inst.mul_fifo_inst.i_wr    ),
  .i_rmul_full ( merge_inst.mul_fifo_inst.o_full  )
);

//--- test/accel_tb.sv
// Accelerator testbench
module accel_tb import accel_pkg::*; ();

  localparam int          SOL_LEN     = SOL_LEN_DEF;
  localparam int          MUL_W       = MUL_W_DEF;
  localparam int unsigned MUL_P       = MUL_P_DEF;
  localparam int          FIFO_DEPTH  = FIFO_DEPTH_DEF;
  localparam int          CYCLE_LIMIT = 4000; // Tests need about 1500 cycles
  localparam int unsigned SEED        = 32'hd5b9;

  logic  i_clk_100;
  logic  i_rst_n;
  logic  i_rx_val;
  cmd_t  i_rx_dat;
  logic  o_tx_val;
  resp_t o_tx_dat;

  // Reference model state
  resp_t       chk_q[$];  // Expected checker responses, oldest first
  resp_t       mul_q[$];  // Expected products, oldest first
  logic [31:0] sol[$];    // Index list of the next solution
  logic [31:0] prev_idx;
  logic [31:0] xor_acc;
  int          idx_cnt;
  logic        order_err;
  logic [3:0]  tag;
  int          cycles = 0;
  logic [3:0]  junk_ops [4] = '{4'h0, 4'h4, 4'h9, 4'hf}; // Opcodes the DUT must drop

  accel_top #(
    .SOL_LEN    ( SOL_LEN    ),
    .MUL_W      ( MUL_W      ),
    .MUL_P      ( MUL_P      ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) accel_top_inst (
    .i_clk_100 ( i_clk_100 ),
    .i_rst_n   ( i_rst_n   ),
    .i_rx_val  ( i_rx_val  ),
    .i_rx_dat  ( i_rx_dat  ),
    .o_tx_val  ( o_tx_val  ),
    .o_tx_dat  ( o_tx_dat  )
  );

  always #5 i_clk_100 = ~i_clk_100;

  always @(posedge i_clk_100) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) abort_run("timeout, responses missing");
  end

  task automatic abort_run(input string why);
    $display("sim failed");
    $fatal(1, "%s", why);
  endtask

  // Advance n edges, leave inputs 1 unit after the edge
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge i_clk_100);
      #1;
    end
  endtask

  task automatic send_word(input cmd_t w);
    i_rx_val = 1'b1;
    i_rx_dat = w;
    idle(1);
    i_rx_val = 1'b0;
  endtask

  task automatic clear_solution_model();
    idx_cnt   = 0;
    xor_acc   = '0;
    order_err = 1'b0;
  endtask

  // One index word, mask predicted from the checker rules
  task automatic send_index(input logic [31:0] idx, input logic last);
    resp_t             exp;
    logic [MASK_W-1:0] mask;
    if (idx_cnt != 0 && idx <= prev_idx) order_err = 1'b1; // Sticky for the solution
    prev_idx = idx;
    idx_cnt++;
    xor_acc ^= idx;
    if (last) begin
      mask             = '0;
      mask[MASK_ORDER] = order_err;
      mask[MASK_COUNT] = (idx_cnt != SOL_LEN);
      mask[MASK_XOR]   = (xor_acc != 0);
      exp = {OP_CHK_IDX, tag, {(PAY_W - MASK_W){1'b0}}, mask}; // Tag of the last word
      chk_q.push_back(exp);
      clear_solution_model();
    end
    send_word({OP_CHK_IDX, tag, last, 23'h0, idx});
    tag++;
  endtask

  // Ascending list whose last index cancels the XOR, with optional faults
  task automatic build_solution(input bit dup, input bit short_list, input bit bad_xor);
    logic [31:0] v;
    logic [31:0] x;
    sol.delete();
    v = '0;
    for (int k = 0; k < SOL_LEN - 3; k++) begin
      v = v + 32'd1 + ($urandom & 32'h000f_ffff); // Stays below bit 28
      sol.push_back(v);
    end
    if (short_list) void'(sol.pop_front());
    if (dup) sol[1] = sol[0];                     // Repeated index
    sol.push_back(32'h2000_0000 | ($urandom & 32'h0fff_ffff));
    sol.push_back(32'h4000_0000 | ($urandom & 32'h0fff_ffff));
    x = '0;
    foreach (sol[k]) x ^= sol[k];
    if (bad_xor) x ^= 32'h1;
    sol.push_back(x); // Bits 30 and 29 set so it tops the list
  endtask

  task automatic send_solution();
    foreach (sol[k]) send_index(sol[k], k == sol.size() - 1);
  endtask

  task automatic send_mul(input logic [MUL_W-1:0] a, input logic [MUL_W-1:0] b);
    resp_t       exp;
    logic [63:0] prod;
    while (mul_q.size() >= FIFO_DEPTH) idle(1); // Outstanding work fits the queue
    prod = (64'(a) * 64'(b)) % 64'(MUL_P);
    exp  = {OP_MODMUL, tag, {(PAY_W - MUL_W){1'b0}}, prod[MUL_W-1:0]};
    mul_q.push_back(exp);
    send_word({OP_MODMUL, tag, {(PAY_W - 2 * MUL_W){1'b0}}, a, b});
    tag++;
  endtask

  task automatic send_reset();
    send_word({OP_USR_RST, tag, {PAY_W{1'b0}}});
    clear_solution_model(); // Partial solution gone
    mul_q.delete();         // Queued and running products gone
  endtask

  task automatic wait_drain();
    while (chk_q.size() != 0 || mul_q.size() != 0) idle(1);
    idle(2);
  endtask

  // Route each response by opcode to its expected queue
  task automatic check_response(input resp_t got);
    resp_t exp;
    case (got[OP_HI:OP_LO])
      OP_CHK_IDX: begin
        assert (chk_q.size() != 0) else abort_run("checker response with nothing expected");
        exp = chk_q.pop_front();
      end
      OP_MODMUL: begin
        assert (mul_q.size() != 0) else abort_run("product response with nothing expected");
        exp = mul_q.pop_front();
      end
      default: abort_run("response with an unknown opcode");
    endcase
    assert (got == exp) else begin
      $display("Fail at %0t: o_tx_dat got %h expected %h", $time, got, exp);
      abort_run("response mismatch");
    end
  endtask

  always @(negedge i_clk_100) begin
    if (i_rst_n && o_tx_val) check_response(o_tx_dat); // Mid-cycle, outputs settled
  end

  initial begin
    void'($urandom(SEED));
    i_clk_100 = 1'b0;
    i_rst_n   = 1'b0;
    i_rx_val  = 1'b0;
    i_rx_dat  = '0;
    tag       = '0;
    clear_solution_model();
    repeat (10) @(posedge i_clk_100);
    #1;
    i_rst_n = 1'b1;
    idle(2);

    // Clean solution, then every mix of order, count and XOR faults
    for (int m = 0; m < 8; m++) begin
      build_solution(m[0], m[1], m[2]);
      send_solution();
    end
    wait_drain();

    // Corner operands then random products
    send_mul('0, MUL_W'($urandom));
    send_mul(MUL_W'($urandom), '0);
    send_mul(MUL_W'(MUL_P - 1), MUL_W'(MUL_P - 1));
    send_mul(MUL_W'(MUL_P - 1), MUL_W'(1));
    send_mul('1, '1); // Both above the modulus
    for (int k = 0; k < 12; k++) send_mul(MUL_W'($urandom), MUL_W'($urandom));
    wait_drain();
    for (int r = 0; r < 2; r++) begin
      for (int k = 0; k < FIFO_DEPTH; k++) send_mul(MUL_W'($urandom), MUL_W'($urandom));
      wait_drain();
    end

    // Sweep so checker and product results land in the same cycle
    for (int d = 12; d <= 20; d++) begin
      send_mul(MUL_W'($urandom), MUL_W'($urandom));
      idle(d);
      build_solution(1'b0, 1'b0, 1'b0);
      send_solution();
      wait_drain();
    end
    send_mul(MUL_W'($urandom), MUL_W'($urandom));
    idle(18);
    for (int k = 0; k < 12; k++) send_index($urandom, 1'b1); // One result per cycle
    wait_drain();
    for (int k = 0; k < FIFO_DEPTH; k++) send_mul(MUL_W'($urandom), MUL_W'($urandom));
    for (int k = 0; k < 3; k++) begin
      build_solution(1'b0, 1'b0, 1'b0);
      send_solution();
    end
    wait_drain();

    // User reset inside a solution
    build_solution(1'b0, 1'b0, 1'b0);
    for (int k = 0; k < 3; k++) send_index(sol[k], 1'b0);
    send_reset();
    build_solution(1'b0, 1'b0, 1'b0);
    send_solution();
    wait_drain();

    // User reset inside a product burst
    for (int k = 0; k < FIFO_DEPTH; k++) send_mul(MUL_W'($urandom), MUL_W'($urandom));
    idle(5);
    send_reset();
    idle(4 * MUL_W); // Any stale product would show up here
    send_mul(MUL_W'(MUL_P - 1), MUL_W'(2));
    build_solution(1'b0, 1'b0, 1'b0);
    send_solution();
    wait_drain();

    // Unknown opcodes alone and inside a solution
    for (int k = 0; k < 4; k++) send_word({junk_ops[k], tag, 24'h0, $urandom});
    build_solution(1'b0, 1'b0, 1'b0);
    foreach (sol[k]) begin
      if (k == 2) send_word({4'hf, tag, 24'h0, 32'h0});
      send_index(sol[k], k == sol.size() - 1);
    end
    wait_drain();
    idle(20);

    if (chk_q.size() == 0 && mul_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("expected responses never arrived");
    end
  end

endmodule
